//--- logic/dcache_pkg.sv
package dcache_pkg;

    // request side
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;

    // line and burst side
    localparam int LINE_W   = 256;
    localparam int BEAT_W   = 64;
    localparam int BEATS    = LINE_W / BEAT_W;       // 4 beats per line
    localparam int OFFSET_W = $clog2(LINE_W / 8);    // byte offset in a line

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] wmask_t;            // one bit per byte
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [LINE_W/8-1:0] line_mask_t;
    typedef logic [BEAT_W-1:0]   beat_t;

    // controller states of the blocking cache
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITEBACK,
        FILL
    } cache_state_e;

endpackage : dcache_pkg

//--- logic/cache_ctrl.sv
module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst,

    // request handshake
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    output logic                  mem_resp_o,

    // tag and line arrays
    input  logic                  hit_i,
    input  logic                  dirty_i,
    input  dcache_pkg::addr_t     victim_addr_i,
    input  dcache_pkg::addr_t     mem_addr_i,
    output logic                  tag_we_o,
    output logic                  dirty_set_o,
    output logic                  fill_we_o,
    output logic                  word_we_o,

    // line port to the serdes
    output logic                  line_read_o,
    output logic                  line_write_o,
    output dcache_pkg::addr_t     line_addr_o,
    input  logic                  line_resp_i
);

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        mem_resp_o   = 1'b0;
        tag_we_o     = 1'b0;
        dirty_set_o  = 1'b0;
        fill_we_o    = 1'b0;
        word_we_o    = 1'b0;
        line_read_o  = 1'b0;
        line_write_o = 1'b0;

        case (state_q)
            dcache_pkg::IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_d = dcache_pkg::COMPARE;
                end
            end
            dcache_pkg::COMPARE: begin
                if (hit_i) begin
                    mem_resp_o  = 1'b1;
                    word_we_o   = mem_write_i;     // masked merge on a write hit
                    dirty_set_o = mem_write_i;
                    state_d     = dcache_pkg::IDLE;
                end else if (dirty_i) begin
                    state_d = dcache_pkg::WRITEBACK;  // victim must go out first
                end else begin
                    state_d = dcache_pkg::FILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                line_write_o = 1'b1;
                if (line_resp_i) begin
                    state_d = dcache_pkg::FILL;
                end
            end
            dcache_pkg::FILL: begin
                line_read_o = 1'b1;
                if (line_resp_i) begin
                    fill_we_o = 1'b1;
                    tag_we_o  = 1'b1;              // tag valid, dirty clear
                    state_d   = dcache_pkg::COMPARE;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // victim address on writeback, else the line holding the request
    always_comb begin
        if (state_q == dcache_pkg::WRITEBACK) begin
            line_addr_o = victim_addr_i;
        end else begin
            line_addr_o = {mem_addr_i[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                           {dcache_pkg::OFFSET_W{1'b0}}};
        end
    end

endmodule : cache_ctrl

//--- logic/tag_store.sv
module tag_store #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::addr_t     addr_i,
    input  logic                  tag_we_i,
    input  logic                  dirty_set_i,
    output logic                  hit_o,
    output logic                  dirty_o,
    output dcache_pkg::addr_t     victim_addr_o
);

    localparam int NUM_SETS = 2 ** SET_BITS;
    localparam int TAG_W    = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - SET_BITS;

    logic [TAG_W-1:0]    tag_q [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [SET_BITS-1:0] index;
    logic [TAG_W-1:0]    tag;

    assign index = addr_i[dcache_pkg::OFFSET_W +: SET_BITS];
    assign tag   = addr_i[dcache_pkg::ADDR_W-1 -: TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_we_i) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;       // fresh line from memory
        end else if (dirty_set_i) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_q[index] <= tag;
        end
    end

    assign hit_o   = valid_q[index] && (tag_q[index] == tag);
    assign dirty_o = valid_q[index] && dirty_q[index];

    // line-aligned address of the resident line
    assign victim_addr_o = {tag_q[index], index, {dcache_pkg::OFFSET_W{1'b0}}};

endmodule : tag_store

//--- logic/line_store.sv
module line_store #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  dcache_pkg::addr_t     addr_i,
    input  dcache_pkg::wmask_t    wmask_i,
    input  dcache_pkg::word_t     wdata_i,
    input  logic                  word_we_i,
    input  logic                  fill_we_i,
    input  dcache_pkg::line_t     fill_line_i,
    output dcache_pkg::word_t     rdata_o,
    output dcache_pkg::line_t     line_o
);

    localparam int NUM_SETS   = 2 ** SET_BITS;
    localparam int WORDS      = dcache_pkg::LINE_W / dcache_pkg::WORD_W;
    localparam int WORD_OFF_W = $clog2(WORDS);
    localparam int BYTE_OFF_W = $clog2(dcache_pkg::WORD_W / 8);
    localparam int LINE_BYTES = dcache_pkg::LINE_W / 8;

    dcache_pkg::line_t       data_q [NUM_SETS];
    logic [SET_BITS-1:0]     index;
    logic [WORD_OFF_W-1:0]   word_off;      // address bits 4 to 2
    dcache_pkg::line_t       wdata_line;
    dcache_pkg::line_mask_t  wmask_line;

    assign index    = addr_i[dcache_pkg::OFFSET_W +: SET_BITS];
    assign word_off = addr_i[BYTE_OFF_W +: WORD_OFF_W];

    // word adapter, replicate data and slide the mask into its slot
    assign wdata_line = {WORDS{wdata_i}};
    assign wmask_line = dcache_pkg::line_mask_t'(wmask_i)
                        << (word_off * (dcache_pkg::WORD_W / 8));

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            data_q[index] <= fill_line_i;              // whole line on a fill
        end else if (word_we_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (wmask_line[i]) begin
                    data_q[index][8*i +: 8] <= wdata_line[8*i +: 8];
                end
            end
        end
    end

    assign line_o  = data_q[index];
    assign rdata_o = line_o[word_off * dcache_pkg::WORD_W +: dcache_pkg::WORD_W];

endmodule : line_store

//--- logic/burst_serdes.sv
module burst_serdes (
    input  logic                  clk,
    input  logic                  rst,

    // line side
    input  logic                  line_read_i,
    input  logic                  line_write_i,
    input  dcache_pkg::addr_t     line_addr_i,
    input  dcache_pkg::line_t     line_wdata_i,
    output dcache_pkg::line_t     line_rdata_o,
    output logic                  line_resp_o,

    // burst memory side
    output dcache_pkg::addr_t     bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output dcache_pkg::beat_t     bmem_wdata_o,
    input  dcache_pkg::beat_t     bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    localparam int CNT_W = $clog2(dcache_pkg::BEATS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_DONE
    } serdes_state_e;

    serdes_state_e      state_q;
    logic [CNT_W-1:0]   beat_q;
    dcache_pkg::line_t  buf_q;      // shift buffer, beat 0 at the bottom
    dcache_pkg::addr_t  addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    beat_q <= '0;
                    if (line_read_i) begin
                        state_q <= S_READ;
                    end else if (line_write_i) begin
                        state_q <= S_WRITE;
                    end
                end
                S_READ, S_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == CNT_W'(dcache_pkg::BEATS - 1)) begin
                            state_q <= S_DONE;      // last beat taken
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;              // one cycle of line_resp
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                addr_q <= line_addr_i;
                buf_q  <= line_wdata_i;             // victim line for a write
            end
            S_READ: begin
                if (bmem_resp_i) begin
                    buf_q <= {bmem_rdata_i, buf_q[dcache_pkg::LINE_W-1:dcache_pkg::BEAT_W]};
                end
            end
            S_WRITE: begin
                if (bmem_resp_i) begin
                    buf_q <= buf_q >> dcache_pkg::BEAT_W;
                end
            end
            default: begin
                buf_q <= buf_q;
            end
        endcase
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == S_READ);
    assign bmem_write_o = (state_q == S_WRITE);
    assign bmem_wdata_o = buf_q[dcache_pkg::BEAT_W-1:0];
    assign line_rdata_o = buf_q;
    assign line_resp_o  = (state_q == S_DONE);

endmodule : burst_serdes

//--- logic/dcache_top.sv
module dcache_top #(
    parameter int SET_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rst,

    // request port
    input  dcache_pkg::addr_t     mem_addr_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  dcache_pkg::wmask_t    mem_wmask_i,
    input  dcache_pkg::word_t     mem_wdata_i,
    output dcache_pkg::word_t     mem_rdata_o,
    output logic                  mem_resp_o,

    // burst memory port
    output dcache_pkg::addr_t     bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output dcache_pkg::beat_t     bmem_wdata_o,
    input  dcache_pkg::beat_t     bmem_rdata_i,
    input  logic                  bmem_resp_i
);

    logic               hit;            // tag_store -> cache_ctrl
    logic               dirty;          // tag_store -> cache_ctrl
    dcache_pkg::addr_t  victim_addr;    // tag_store -> cache_ctrl

    logic               tag_we;         // cache_ctrl -> tag_store
    logic               dirty_set;      // cache_ctrl -> tag_store
    logic               fill_we;        // cache_ctrl -> line_store
    logic               word_we;        // cache_ctrl -> line_store

    logic               line_read;      // cache_ctrl -> burst_serdes
    logic               line_write;     // cache_ctrl -> burst_serdes
    dcache_pkg::addr_t  line_addr;      // cache_ctrl -> burst_serdes
    logic               line_resp;      // burst_serdes -> cache_ctrl
    dcache_pkg::line_t  line_rdata;     // burst_serdes -> line_store
    dcache_pkg::line_t  line_wdata;     // line_store -> burst_serdes

    cache_ctrl ctrl (
        .clk            (clk),
        .rst            (rst),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .mem_resp_o     (mem_resp_o),
        .hit_i          (hit),
        .dirty_i        (dirty),
        .victim_addr_i  (victim_addr),
        .mem_addr_i     (mem_addr_i),
        .tag_we_o       (tag_we),
        .dirty_set_o    (dirty_set),
        .fill_we_o      (fill_we),
        .word_we_o      (word_we),
        .line_read_o    (line_read),
        .line_write_o   (line_write),
        .line_addr_o    (line_addr),
        .line_resp_i    (line_resp)
    );

    tag_store #(
        .SET_BITS       (SET_BITS)
    ) tags (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (mem_addr_i),
        .tag_we_i       (tag_we),
        .dirty_set_i    (dirty_set),
        .hit_o          (hit),
        .dirty_o        (dirty),
        .victim_addr_o  (victim_addr)
    );

    line_store #(
        .SET_BITS       (SET_BITS)
    ) lines (
        .clk            (clk),
        .addr_i         (mem_addr_i),
        .wmask_i        (mem_wmask_i),
        .wdata_i        (mem_wdata_i),
        .word_we_i      (word_we),
        .fill_we_i      (fill_we),
        .fill_line_i    (line_rdata),   // line from the serdes on a fill
        .rdata_o        (mem_rdata_o),
        .line_o         (line_wdata)    // victim line for writeback
    );

    burst_serdes serdes (
        .clk            (clk),
        .rst            (rst),
        .line_read_i    (line_read),
        .line_write_i   (line_write),
        .line_addr_i    (line_addr),
        .line_wdata_i   (line_wdata),
        .line_rdata_o   (line_rdata),
        .line_resp_o    (line_resp),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : dcache_top

//--- testbench/burst_mem_model.sv
module burst_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::addr_t    bmem_addr_i,
    input  logic                 bmem_read_i,
    input  logic                 bmem_write_i,
    input  dcache_pkg::beat_t    bmem_wdata_i,
    output dcache_pkg::beat_t    bmem_rdata_o,
    output logic                 bmem_resp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = 3;        // cycles before the first beat
    localparam int DEPTH   = 4096;     // words, low 16 KB of the address space

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_BEATS} model_state_e;

    logic [31:0]        mem [DEPTH];
    logic               written [DEPTH];
    model_state_e       state;
    logic               is_write;
    dcache_pkg::addr_t  base;
    int                 wait_cnt;
    int                 beat_cnt;
    int                 widx;
    int                 read_bursts;
    int                 write_bursts;
    dcache_pkg::addr_t  last_read_addr;
    dcache_pkg::addr_t  last_write_addr;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            written[i] = 1'b0;
        end
    end

    // a word never written reads back as its own address with a pattern
    function automatic logic [31:0] peek_word(dcache_pkg::addr_t a);
        dcache_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (written[w[13:2]]) begin
            return mem[w[13:2]];
        end
        return w ^ 32'hA5A5_0000;
    endfunction

    function automatic dcache_pkg::beat_t beat_at(dcache_pkg::addr_t a);
        return {peek_word(a + 32'd4), peek_word(a)};   // lower address in the low half
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            state        <= M_IDLE;
            bmem_resp_o  <= 1'b0;
            bmem_rdata_o <= '0;
            read_bursts  <= 0;
            write_bursts <= 0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (bmem_read_i || bmem_write_i) begin
                        base     <= bmem_addr_i;
                        is_write <= bmem_write_i;
                        wait_cnt <= 1;
                        state    <= M_WAIT;
                        if (bmem_write_i) begin
                            write_bursts    <= write_bursts + 1;
                            last_write_addr <= bmem_addr_i;
                        end else begin
                            read_bursts    <= read_bursts + 1;
                            last_read_addr <= bmem_addr_i;
                        end
                    end
                end
                M_WAIT: begin
                    wait_cnt <= wait_cnt + 1;
                    if (wait_cnt == LATENCY) begin
                        bmem_resp_o  <= 1'b1;
                        bmem_rdata_o <= beat_at(base);
                        beat_cnt     <= 0;
                        state        <= M_BEATS;
                    end
                end
                default: begin
                    if (is_write) begin
                        widx = int'(base[13:2]) + 2 * beat_cnt;
                        mem[widx]         <= bmem_wdata_i[31:0];
                        mem[widx + 1]     <= bmem_wdata_i[63:32];
                        written[widx]     <= 1'b1;
                        written[widx + 1] <= 1'b1;
                    end
                    bmem_rdata_o <= beat_at(base + 32'(8 * (beat_cnt + 1)));
                    beat_cnt     <= beat_cnt + 1;
                    if (beat_cnt == dcache_pkg::BEATS - 1) begin
                        bmem_resp_o <= 1'b0;      // burst complete
                        state       <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule : burst_mem_model

//--- testbench/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SET_BITS       = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_RANDOM     = 250;
    localparam int REQ_BUDGET     = 300;     // requests over all tests, rounded up
    localparam int CYCLES_PER_REQ = 30;      // dirty miss with memory latency
    localparam int MAX_CYCLES     = 2 * REQ_BUDGET * CYCLES_PER_REQ + 2000;

    localparam dcache_pkg::addr_t LINE_A    = 32'h0000_1040;
    localparam dcache_pkg::addr_t LINE_B    = LINE_A + (32'd1 << (dcache_pkg::OFFSET_W + SET_BITS));
    localparam dcache_pkg::addr_t RAND_BASE = 32'h0000_2000;

    logic               clk;
    logic               rst;
    dcache_pkg::addr_t  mem_addr_i;
    logic               mem_read_i;
    logic               mem_write_i;
    dcache_pkg::wmask_t mem_wmask_i;
    dcache_pkg::word_t  mem_wdata_i;
    dcache_pkg::word_t  mem_rdata_o;
    logic               mem_resp_o;
    dcache_pkg::addr_t  bmem_addr_o;
    logic               bmem_read_o;
    logic               bmem_write_o;
    dcache_pkg::beat_t  bmem_wdata_o;
    dcache_pkg::beat_t  bmem_rdata_i;
    logic               bmem_resp_i;

    int                 error_count;
    int                 request_count;
    int                 last_latency;
    integer             seed;
    logic [31:0]        sb_data [4096];     // expected memory image, same window as the model
    logic               sb_written [4096];

    dcache_top #(.SET_BITS(SET_BITS)) dut (
        .clk(clk), .rst(rst),
        .mem_addr_i(mem_addr_i), .mem_read_i(mem_read_i), .mem_write_i(mem_write_i),
        .mem_wmask_i(mem_wmask_i), .mem_wdata_i(mem_wdata_i),
        .mem_rdata_o(mem_rdata_o), .mem_resp_o(mem_resp_o),
        .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o), .bmem_write_o(bmem_write_o),
        .bmem_wdata_o(bmem_wdata_o), .bmem_rdata_i(bmem_rdata_i), .bmem_resp_i(bmem_resp_i)
    );

    burst_mem_model mem_model (
        .clk(clk), .rst(rst),
        .bmem_addr_i(bmem_addr_o), .bmem_read_i(bmem_read_o), .bmem_write_i(bmem_write_o),
        .bmem_wdata_i(bmem_wdata_o), .bmem_rdata_o(bmem_rdata_i), .bmem_resp_o(bmem_resp_i)
    );

    always #2 clk = ~clk;

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        error_count++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    function automatic dcache_pkg::word_t expected_word(dcache_pkg::addr_t a);
        if (sb_written[a[13:2]]) begin
            return sb_data[a[13:2]];
        end
        return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    task automatic update_scoreboard(dcache_pkg::addr_t a, dcache_pkg::wmask_t mask,
                                     dcache_pkg::word_t data);
        dcache_pkg::word_t w;
        w = expected_word(a);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[8*b +: 8] = data[8*b +: 8];     // only enabled bytes change
            end
        end
        sb_data[a[13:2]]    = w;
        sb_written[a[13:2]] = 1'b1;
    endtask

    // latency counts rising edges from the request to the response cycle
    task automatic wait_resp();
        last_latency = 0;
        @(negedge clk);
        while (!mem_resp_o) begin
            last_latency++;
            @(negedge clk);
        end
        request_count++;
    endtask

    task automatic cpu_read(dcache_pkg::addr_t a, dcache_pkg::word_t expected);
        @(posedge clk);
        mem_addr_i <= a;
        mem_read_i <= 1'b1;
        wait_resp();
        if (mem_rdata_o !== expected) begin
            report_mismatch("mem_rdata_o", expected, mem_rdata_o);
        end
        @(posedge clk);
        mem_read_i <= 1'b0;
    endtask

    task automatic cpu_write(dcache_pkg::addr_t a, dcache_pkg::wmask_t mask,
                             dcache_pkg::word_t data);
        @(posedge clk);
        mem_addr_i  <= a;
        mem_wmask_i <= mask;
        mem_wdata_i <= data;
        mem_write_i <= 1'b1;
        wait_resp();
        update_scoreboard(a, mask, data);
        @(posedge clk);
        mem_write_i <= 1'b0;
    endtask

    task automatic check_idle_outputs();
        if (mem_resp_o !== 1'b0) begin
            report_mismatch("mem_resp_o", 0, mem_resp_o);
        end
        if (bmem_read_o !== 1'b0) begin
            report_mismatch("bmem_read_o", 0, bmem_read_o);
        end
        if (bmem_write_o !== 1'b0) begin
            report_mismatch("bmem_write_o", 0, bmem_write_o);
        end
    endtask

    task automatic test_reset();
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        rst <= 1'b0;                      // 16th rising edge in reset
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_read_miss();
        int reads;
        reads = mem_model.read_bursts;
        cpu_read(LINE_A + 32'd8, (LINE_A + 32'd8) ^ 32'hA5A5_0000);
        if (mem_model.read_bursts != reads + 1) begin
            report_mismatch("read bursts", reads + 1, mem_model.read_bursts);
        end
        if (mem_model.last_read_addr !== LINE_A) begin
            report_mismatch("bmem_addr_o", LINE_A, mem_model.last_read_addr);
        end
    endtask

    task automatic test_read_hit();
        int bursts;
        bursts = mem_model.read_bursts + mem_model.write_bursts;
        cpu_read(LINE_A + 32'd20, expected_word(LINE_A + 32'd20));
        if (last_latency != 1) begin
            report_mismatch("mem_resp_o latency", 1, last_latency);
        end
        if (mem_model.read_bursts + mem_model.write_bursts != bursts) begin
            report_mismatch("burst count", bursts, mem_model.read_bursts + mem_model.write_bursts);
        end
    endtask

    task automatic test_masked_write();
        int bursts;
        bursts = mem_model.read_bursts + mem_model.write_bursts;
        cpu_write(LINE_A + 32'd4, 4'b0110, 32'hDEAD_BEEF);
        cpu_read(LINE_A + 32'd4, expected_word(LINE_A + 32'd4));
        cpu_write(LINE_A + 32'd28, 4'b1001, 32'h1234_5678);
        cpu_read(LINE_A + 32'd28, expected_word(LINE_A + 32'd28));
        if (mem_model.read_bursts + mem_model.write_bursts != bursts) begin
            report_mismatch("burst count", bursts, mem_model.read_bursts + mem_model.write_bursts);
        end
    endtask

    task automatic test_dirty_eviction();
        int reads;
        int writes;
        reads  = mem_model.read_bursts;
        writes = mem_model.write_bursts;
        cpu_read(LINE_B, expected_word(LINE_B));     // same index, other tag
        if (mem_model.write_bursts != writes + 1) begin
            report_mismatch("write bursts", writes + 1, mem_model.write_bursts);
        end
        if (mem_model.read_bursts != reads + 1) begin
            report_mismatch("read bursts", reads + 1, mem_model.read_bursts);
        end
        if (mem_model.last_write_addr !== LINE_A) begin
            report_mismatch("bmem_addr_o", LINE_A, mem_model.last_write_addr);
        end
        if (mem_model.peek_word(LINE_A + 32'd4) !== expected_word(LINE_A + 32'd4)) begin
            report_mismatch("memory word", expected_word(LINE_A + 32'd4),
                            mem_model.peek_word(LINE_A + 32'd4));
        end
        cpu_read(LINE_A + 32'd4, expected_word(LINE_A + 32'd4));   // refill, clean victim
        if (mem_model.write_bursts != writes + 1) begin
            report_mismatch("write bursts", writes + 1, mem_model.write_bursts);
        end
    endtask

    task automatic test_random_mix();
        dcache_pkg::addr_t  a;
        dcache_pkg::wmask_t mask;
        dcache_pkg::word_t  data;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = RAND_BASE + (32'($random(seed)) & 32'h0000_03FC);  // 32 lines, 2 tags per set
            if (($random(seed) & 1) == 1) begin
                mask = dcache_pkg::wmask_t'($random(seed));
                data = $random(seed);
                if (mask == 4'b0000) begin
                    mask = 4'b1111;
                end
                cpu_write(a, mask, data);
            end else begin
                cpu_read(a, expected_word(a));
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        mem_addr_i    = '0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        mem_wmask_i   = '0;
        mem_wdata_i   = '0;
        error_count   = 0;
        request_count = 0;
        seed          = 70;
        for (int i = 0; i < 4096; i++) begin
            sb_written[i] = 1'b0;
        end
        test_reset();
        test_read_miss();
        test_read_hit();
        test_masked_write();
        test_dirty_eviction();
        test_random_mix();
        $display("%0d requests completed, %0d errors", request_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_dcache

//--- dcache_top.f
logic/dcache_pkg.sv
logic/cache_ctrl.sv
logic/tag_store.sv
logic/line_store.sv
logic/burst_serdes.sv
logic/dcache_top.sv
testbench/burst_mem_model.sv
testbench/tb_dcache.sv
